/* common/video_pkg.sv */
package video_pkg;

    // chip model, bit 0 marks the PAL parts
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0, // NTSC 520x263
        CHIP_6569R3   = 2'd1, // PAL 504x312
        CHIP_6567R56A = 2'd2, // NTSC 512x262
        CHIP_6569R1   = 2'd3  // PAL 504x312
    } chip_e;

    // native raster counters as delivered by the video chip
    localparam int RASTER_X_W = 10;
    localparam int RASTER_Y_W = 9;

    // output counters, wide enough for doubled resolution
    localparam int H_COUNT_W = 11;
    localparam int V_COUNT_W = 10;

    localparam int COLOR_W = 4;        // palette index
    localparam int LINEBUF_ADDR_W = 11; // covers the doubled line too

    typedef logic [COLOR_W-1:0]   color_t;
    typedef logic [H_COUNT_W-1:0] h_count_t;
    typedef logic [V_COUNT_W-1:0] v_count_t;

    // resolution mode, latched at the raster origin
    typedef struct packed {
        logic native_x; // 1: native width, 0: doubled
        logic native_y; // 1: native height, 0: line doubled
    } scan_mode_t;

endpackage

/* common/scan_timing_pkg.sv */
package scan_timing_pkg;

    // full timing set for one chip and mode, in output counter units
    typedef struct packed {
        video_pkg::h_count_t max_width; // last h_count of a line
        video_pkg::h_count_t ha_end;
        video_pkg::h_count_t hs_sta;
        video_pkg::h_count_t hs_end;
        video_pkg::h_count_t ha_sta;
        video_pkg::v_count_t max_height; // last v_count of a frame
        video_pkg::v_count_t va_end;
        video_pkg::v_count_t va_sta;
        video_pkg::v_count_t vs_sta;
        video_pkg::v_count_t vs_end;
    } scan_timing_t;

    typedef struct packed {
        video_pkg::h_count_t h_count;
        video_pkg::v_count_t v_count;
    } scan_pos_t;

    // PAL 504x312
    localparam video_pkg::h_count_t PAL_MAX_W  = 11'd503;
    localparam video_pkg::v_count_t PAL_MAX_H  = 10'd311;
    localparam video_pkg::h_count_t PAL_HA_END = 11'd0;
    localparam video_pkg::h_count_t PAL_HS_STA = 11'd10;  // fporch 10
    localparam video_pkg::h_count_t PAL_HS_END = 11'd70;  // sync 60
    localparam video_pkg::h_count_t PAL_HA_STA = 11'd90;  // bporch 20
    // blanking wraps through line 0, so these two swap meaning on PAL
    localparam video_pkg::v_count_t PAL_VA_END = 10'd20;  // really active start
    localparam video_pkg::v_count_t PAL_VA_STA = 10'd284; // really active end
    localparam video_pkg::v_count_t PAL_VS_STA = 10'd289;
    localparam video_pkg::v_count_t PAL_VS_END = 10'd291;

    // both NTSC parts share porches and sync
    localparam video_pkg::h_count_t NTSC_HA_END = 11'd0;
    localparam video_pkg::h_count_t NTSC_HS_STA = 11'd10;
    localparam video_pkg::h_count_t NTSC_HS_END = 11'd70;
    localparam video_pkg::h_count_t NTSC_HA_STA = 11'd80;
    localparam video_pkg::v_count_t NTSC_VA_END = 10'd11;
    localparam video_pkg::v_count_t NTSC_VS_STA = 10'd19;
    localparam video_pkg::v_count_t NTSC_VS_END = 10'd22;
    localparam video_pkg::v_count_t NTSC_VA_STA = 10'd24;

    localparam video_pkg::h_count_t NTSC_R8_MAX_W   = 11'd519;
    localparam video_pkg::v_count_t NTSC_R8_MAX_H   = 10'd262;
    localparam video_pkg::h_count_t NTSC_R56A_MAX_W = 11'd511;
    localparam video_pkg::v_count_t NTSC_R56A_MAX_H = 10'd261;

    // vertical blank test, first and last lines split at the h blank edges
    // so the window neither opens early nor closes late within a line
    function automatic logic v_blank(scan_pos_t pos, scan_timing_t t, logic pal);
        logic in_win;
        in_win = ((pos.v_count == t.va_end && pos.h_count >= t.ha_end) ||
                  pos.v_count > t.va_end) &&
                 ((pos.v_count == t.va_sta && pos.h_count < t.ha_sta) ||
                  pos.v_count < t.va_sta);
        return pal ? ~in_win : in_win; // PAL window is the active part
    endfunction

endpackage

/* logic/linebuf_ram.sv */
// one raster line of colour indices, single port
module linebuf_ram (
    input  logic                                clk_dot4x,
    input  logic                                we,
    input  logic [video_pkg::LINEBUF_ADDR_W-1:0] addr,
    input  video_pkg::color_t                   din,
    output video_pkg::color_t                   dout
);

    video_pkg::color_t mem [2**video_pkg::LINEBUF_ADDR_W]; // line storage

    always_ff @(posedge clk_dot4x) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr]; // read-first, one cycle latency
    end

endmodule

/* scan_timing/timing_table.sv */
module timing_table (
    input  logic                          clk_dot4x,
    input  logic                          rst,
    input  video_pkg::chip_e              chip,
    input  video_pkg::scan_mode_t         mode,
    output scan_timing_pkg::scan_timing_t timing
);

    scan_timing_pkg::scan_timing_t native_t; // table entry at native res
    scan_timing_pkg::scan_timing_t scaled_t; // after per-dimension doubling

    // native table lookup
    always_comb begin
        native_t = '{
            max_width:  scan_timing_pkg::NTSC_R8_MAX_W,
            ha_end:     scan_timing_pkg::NTSC_HA_END,
            hs_sta:     scan_timing_pkg::NTSC_HS_STA,
            hs_end:     scan_timing_pkg::NTSC_HS_END,
            ha_sta:     scan_timing_pkg::NTSC_HA_STA,
            max_height: scan_timing_pkg::NTSC_R8_MAX_H,
            va_end:     scan_timing_pkg::NTSC_VA_END,
            va_sta:     scan_timing_pkg::NTSC_VA_STA,
            vs_sta:     scan_timing_pkg::NTSC_VS_STA,
            vs_end:     scan_timing_pkg::NTSC_VS_END
        };
        case (chip)
            video_pkg::CHIP_6569R3, video_pkg::CHIP_6569R1: begin
                native_t.max_width  = scan_timing_pkg::PAL_MAX_W;
                native_t.ha_end     = scan_timing_pkg::PAL_HA_END;
                native_t.hs_sta     = scan_timing_pkg::PAL_HS_STA;
                native_t.hs_end     = scan_timing_pkg::PAL_HS_END;
                native_t.ha_sta     = scan_timing_pkg::PAL_HA_STA;
                native_t.max_height = scan_timing_pkg::PAL_MAX_H;
                native_t.va_end     = scan_timing_pkg::PAL_VA_END;
                native_t.va_sta     = scan_timing_pkg::PAL_VA_STA;
                native_t.vs_sta     = scan_timing_pkg::PAL_VS_STA;
                native_t.vs_end     = scan_timing_pkg::PAL_VS_END;
            end
            video_pkg::CHIP_6567R56A: begin
                native_t.max_width  = scan_timing_pkg::NTSC_R56A_MAX_W; // 512 wide
                native_t.max_height = scan_timing_pkg::NTSC_R56A_MAX_H; // 262 lines
            end
            default: ; // 6567R8 defaults above
        endcase
    end

    // double each non-native dimension, maxima become 2*(max+1)-1
    always_comb begin
        scaled_t = native_t;
        if (!mode.native_x) begin
            scaled_t.max_width = (native_t.max_width << 1) | 11'd1;
            scaled_t.ha_end    = native_t.ha_end << 1;
            scaled_t.hs_sta    = native_t.hs_sta << 1;
            scaled_t.hs_end    = native_t.hs_end << 1;
            scaled_t.ha_sta    = native_t.ha_sta << 1;
        end
        if (!mode.native_y) begin
            scaled_t.max_height = (native_t.max_height << 1) | 10'd1;
            scaled_t.va_end     = native_t.va_end << 1;
            scaled_t.va_sta     = native_t.va_sta << 1;
            scaled_t.vs_sta     = native_t.vs_sta << 1;
            scaled_t.vs_end     = native_t.vs_end << 1;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            timing <= '0;
        end else begin
            timing <= scaled_t; // follows chip/mode one cycle later
        end
    end

endmodule

/* scan_timing/scan_counter.sv */
module scan_counter (
    input  logic                             clk_dot4x,
    input  logic                             rst,
    input  video_pkg::chip_e                 chip,
    input  logic                             native_x_in,
    input  logic                             native_y_in,
    input  logic [video_pkg::RASTER_X_W-1:0] raster_x,
    input  logic [video_pkg::RASTER_Y_W-1:0] raster_y,
    input  scan_timing_pkg::scan_timing_t    timing,
    output video_pkg::scan_mode_t            mode,
    output scan_timing_pkg::scan_pos_t       pos,
    output logic                             half_bright
);

    logic [1:0] phase;  // dot4x sub-phase
    logic       advance; // step the output counters this cycle
    logic       origin;  // native raster at (0,0)
    logic       v_blank; // current line outside vertical active range

    assign origin  = (raster_x == '0) && (raster_y == '0);
    assign v_blank = scan_timing_pkg::v_blank(pos, timing, chip[0]);

    // both doubled: every cycle, one native: phases 1 and 3, both native: phase 1
    always_comb begin
        case ({mode.native_x, mode.native_y})
            2'b00:   advance = 1'b1;
            2'b11:   advance = (phase == 2'd1);
            default: advance = phase[0];
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase       <= 2'd1;
            mode        <= '{native_x: native_x_in, native_y: native_y_in};
            pos         <= '0;
            half_bright <= 1'b0;
        end else begin
            phase <= phase + 2'd1;
            if (advance) begin
                if (pos.h_count < timing.max_width) begin
                    pos.h_count <= pos.h_count + 11'd1;
                end else begin
                    pos.h_count <= '0; // end of line
                    if (pos.v_count < timing.max_height) begin
                        pos.v_count <= pos.v_count + 10'd1;
                    end else begin
                        pos.v_count <= '0;
                    end
                    // alternate within the active picture, restart each frame
                    half_bright <= v_blank ? 1'b0 : ~half_bright;
                end
            end
            // resync: next wrap lands on line 0 with the chip's line 0
            if (origin) begin
                pos.v_count <= timing.max_height;
                mode        <= '{native_x: native_x_in, native_y: native_y_in};
            end
        end
    end

endmodule

/* scan_timing/sync_gen.sv */
module sync_gen (
    input  scan_timing_pkg::scan_pos_t    pos,
    input  scan_timing_pkg::scan_timing_t timing,
    input  video_pkg::chip_e              chip,
    input  logic                          hpolarity,    // 1: active high
    input  logic                          vpolarity,    // 1: active high
    input  logic                          enable_csync,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          active
);

    logic hsync_ah; // active-high versions
    logic vsync_ah;
    logic csync_ah;
    logic h_blank;

    assign hsync_ah = (pos.h_count >= timing.hs_sta) && (pos.h_count <= timing.hs_end);

    // vsync edges are aligned to the hsync start/end, not to h_count 0
    assign vsync_ah = ((pos.v_count == timing.vs_sta && pos.h_count >= timing.hs_sta) ||
                       pos.v_count > timing.vs_sta) &&
                      (pos.v_count < timing.vs_end ||
                       (pos.v_count == timing.vs_end && pos.h_count < timing.hs_end));

    assign csync_ah = hsync_ah | vsync_ah;

    assign h_blank = (pos.h_count >= timing.ha_end) && (pos.h_count <= timing.ha_sta);

    // blank on either axis kills active
    assign active = ~(h_blank | scan_timing_pkg::v_blank(pos, timing, chip[0]));

    always_comb begin
        if (enable_csync) begin
            hsync = hpolarity ? csync_ah : ~csync_ah; // composite on the hsync pin
            vsync = 1'b0;
        end else begin
            hsync = hpolarity ? hsync_ah : ~hsync_ah;
            vsync = vpolarity ? vsync_ah : ~vsync_ah;
        end
    end

endmodule

/* line_doubler/line_doubler.sv */
// ping-pong line buffer, one native line written while the previous is read
// twice over at output rate
module line_doubler (
    input  logic                             clk_dot4x,
    input  logic                             rst,
    input  logic [3:0]                       dot_rising,
    input  logic [video_pkg::RASTER_X_W-1:0] raster_x,
    input  video_pkg::h_count_t              h_count,
    input  video_pkg::color_t                pixel_color3,
    output video_pkg::color_t                pixel_color4
);

    logic                                active_buf; // 1: write buf 0, read buf 1
    logic [video_pkg::LINEBUF_ADDR_W-1:0] wr_addr;
    logic [video_pkg::LINEBUF_ADDR_W-1:0] addr0;
    logic [video_pkg::LINEBUF_ADDR_W-1:0] addr1;
    video_pkg::color_t                   dout0;
    video_pkg::color_t                   dout1;

    assign wr_addr = {1'b0, raster_x}; // native x always fits in the low bits

    // the writing buffer follows raster_x, the other one h_count
    assign addr0 = active_buf ? wr_addr : h_count;
    assign addr1 = active_buf ? h_count : wr_addr;

    linebuf_ram u_buf0 (
        .clk_dot4x (clk_dot4x),
        .we        (active_buf),
        .addr      (addr0),
        .din       (pixel_color3),
        .dout      (dout0)
    );

    linebuf_ram u_buf1 (
        .clk_dot4x (clk_dot4x),
        .we        (~active_buf),
        .addr      (addr1),
        .din       (pixel_color3),
        .dout      (dout1)
    );

    // swap at the start of each native line
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active_buf <= 1'b0;
        end else if (dot_rising[1] && raster_x == '0) begin
            active_buf <= ~active_buf;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        pixel_color4 <= active_buf ? dout1 : dout0; // second pipeline stage
    end

endmodule

/* logic/hires_vga_sync.sv */
module hires_vga_sync (
    input  logic                             clk_dot4x,
    input  logic                             rst,
    input  video_pkg::chip_e                 chip,
    input  logic [3:0]                       dot_rising,
    input  logic                             native_x_in,
    input  logic                             native_y_in,
    input  logic                             hpolarity,
    input  logic                             vpolarity,
    input  logic                             enable_csync,
    input  logic [video_pkg::RASTER_X_W-1:0] raster_x,  // native raster position
    input  logic [video_pkg::RASTER_Y_W-1:0] raster_y,
    input  video_pkg::color_t                pixel_color3,
    output logic                             hsync,
    output logic                             vsync,
    output logic                             active,
    output video_pkg::color_t                pixel_color4,
    output logic                             half_bright
);

    video_pkg::scan_mode_t         mode;   // latched resolution mode
    scan_timing_pkg::scan_timing_t timing; // registered timing table
    scan_timing_pkg::scan_pos_t    pos;    // output scan position

    timing_table u_timing_table (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .mode      (mode),
        .timing    (timing)
    );

    scan_counter u_scan_counter (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .chip        (chip),
        .native_x_in (native_x_in),
        .native_y_in (native_y_in),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .timing      (timing),
        .mode        (mode),
        .pos         (pos),
        .half_bright (half_bright)
    );

    sync_gen u_sync_gen (
        .pos          (pos),
        .timing       (timing),
        .chip         (chip),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active)
    );

    line_doubler u_line_doubler (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .dot_rising   (dot_rising),
        .raster_x     (raster_x),
        .h_count      (pos.h_count),
        .pixel_color3 (pixel_color3),
        .pixel_color4 (pixel_color4)
    );

endmodule

/* dv/tb_clock.sv */
module tb_clock (
    output logic clk_dot4x,
    output logic rst
);

    localparam int PERIOD     = 100;
    localparam int RST_CYCLES = 10;

    initial begin
        clk_dot4x = 1'b0;
        forever #(PERIOD / 2) clk_dot4x = ~clk_dot4x;
    end

    // sync reset, dropped just after the tenth rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_dot4x);
        #1;
        rst = 1'b0;
    end

endmodule

/* dv/tb_hires_vga_sync.sv */
module tb_hires_vga_sync;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;             // input skew after the rising edge
    localparam int PAL_LINE_CYC    = 504 * 4;        // 504 dots of 4 clocks
    localparam int PAL_FRAME_CYC   = 312 * PAL_LINE_CYC;
    localparam int WATCHDOG_CYC    = 6 * PAL_FRAME_CYC;
    localparam int NTSC_ACTIVE_CYC = (519 - 80) * 4; // h 81 to 519 at 4 clocks per dot

    logic                 clk_dot4x;
    logic                 rst;
    video_pkg::chip_e     chip;
    logic [3:0]           dot_rising;
    logic                 native_x_in;
    logic                 native_y_in;
    logic                 hpolarity;
    logic                 vpolarity;
    logic                 enable_csync;
    logic [9:0]           raster_x;
    logic [8:0]           raster_y;
    video_pkg::color_t    pixel_color3;
    logic                 hsync;
    logic                 vsync;
    logic                 active;
    video_pkg::color_t    pixel_color4;
    logic                 half_bright;

    tb_clock u_clock (
        .clk_dot4x (clk_dot4x),
        .rst       (rst)
    );

    hires_vga_sync UUT (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .chip         (chip),
        .dot_rising   (dot_rising),
        .native_x_in  (native_x_in),
        .native_y_in  (native_y_in),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .pixel_color3 (pixel_color3),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .pixel_color4 (pixel_color4),
        .half_bright  (half_bright)
    );

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("** Error @ %0t: %s, expected %b, got %b", $time, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_color(input video_pkg::color_t actual, input video_pkg::color_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error @ %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("** Error @ %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "count mismatch");
        end
    endtask

    // returns on the sample where hsync has just entered the given level
    task automatic wait_hsync_entry(input logic level);
        logic prev;
        @(negedge clk_dot4x);
        prev = hsync;
        @(negedge clk_dot4x);
        while (!(hsync == level && prev != level)) begin
            prev = hsync;
            @(negedge clk_dot4x);
        end
    endtask

    // pulse width and period of hsync at one level after skipping a line
    task automatic measure_hsync(input logic level, output int width, output int period);
        wait_hsync_entry(level);
        wait_hsync_entry(level); // first line may be cut short by a mode change
        width  = 0;
        period = 0;
        while (hsync == level) begin
            width++;
            period++;
            @(negedge clk_dot4x);
        end
        while (hsync != level) begin
            period++;
            @(negedge clk_dot4x);
        end
    endtask

    // new chip and mode latched by a one-cycle pulse at the raster origin
    task automatic set_mode(input video_pkg::chip_e new_chip, input logic nx, input logic ny);
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        chip        = new_chip;
        native_x_in = nx;
        native_y_in = ny;
        raster_x    = '0;
        raster_y    = '0;
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        raster_x = 10'd1;
        raster_y = 9'd1; // stay off the origin
    endtask

    // fill one native line with a single colour and swap the buffers
    task automatic fill_and_swap(input video_pkg::color_t color);
        int x;
        for (x = 0; x < 1024; x++) begin
            @(posedge clk_dot4x);
            #DRIVE_DELAY;
            raster_x     = 10'(x);
            pixel_color3 = color;
        end
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        raster_x   = '0;
        dot_rising = 4'b0010; // swap strobe
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        raster_x     = 10'd1;
        dot_rising   = 4'b0000;
        pixel_color3 = '0;
    endtask

    // checks one whole active stretch of the next output line
    task automatic check_line(input video_pkg::color_t color, input int active_cycles);
        int   n;
        logic prev_a;
        @(negedge clk_dot4x);
        prev_a = active;
        @(negedge clk_dot4x);
        while (!(active && !prev_a)) begin
            prev_a = active;
            @(negedge clk_dot4x);
        end
        n = 0;
        while (active) begin
            if (n >= 4) begin
                check_color(pixel_color4, color, "pixel_color4 inside active line");
            end
            n++;
            @(negedge clk_dot4x);
        end
        check_count(n, active_cycles, "active stretch length");
    endtask

    task automatic test_native_pal;
        int width;
        int period;
        set_mode(video_pkg::CHIP_6569R3, 1'b1, 1'b1);
        measure_hsync(1'b1, width, period);
        check_count(period, 504 * 4, "PAL native line period");
        check_count(width, (70 - 10 + 1) * 4, "PAL native hsync width");
    endtask

    task automatic test_doubled_ntsc;
        int width;
        int period;
        set_mode(video_pkg::CHIP_6567R8, 1'b0, 1'b0);
        measure_hsync(1'b1, width, period);
        check_count(period, 2 * 520, "NTSC R8 doubled line period"); // one step per clock
        check_count(width, 2 * 70 - 2 * 10 + 1, "NTSC R8 doubled hsync width");
    endtask

    task automatic test_polarity_csync;
        int width;
        int period;
        int run;
        int longest;
        int n;
        set_mode(video_pkg::CHIP_6569R3, 1'b1, 1'b1);
        hpolarity = 1'b0;
        measure_hsync(1'b0, width, period); // low pulses now
        check_count(period, 504 * 4, "inverted hsync period");
        check_count(width, (70 - 10 + 1) * 4, "inverted hsync low width");
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        hpolarity    = 1'b1;
        enable_csync = 1'b1;
        wait_hsync_entry(1'b0);
        run     = 0;
        longest = 0;
        // long enough for one complete vsync stretch wherever the frame starts
        for (n = 0; n < PAL_FRAME_CYC + 3 * PAL_LINE_CYC; n++) begin
            @(negedge clk_dot4x);
            check_bit(vsync, 1'b0, "vsync held low with csync");
            if (hsync) begin
                run++;
            end else begin
                longest = (run > longest) ? run : longest;
                run     = 0;
            end
        end
        // from (vs_sta, hs_sta) through hs_end of line vs_end
        check_count(longest, (2 * 504 + (70 - 10 + 1)) * 4, "csync run across vsync lines");
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        enable_csync = 1'b0;
    endtask

    task automatic test_resync;
        int   rises;
        logic prev_h;
        logic prev_v;
        logic done;
        set_mode(video_pkg::CHIP_6567R8, 1'b1, 1'b1);
        wait_hsync_entry(1'b1);
        wait_hsync_entry(1'b1);
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        raster_x = '0;
        raster_y = '0;
        @(posedge clk_dot4x);
        #DRIVE_DELAY;
        raster_x = 10'd1;
        raster_y = 9'd1;
        @(negedge clk_dot4x);
        prev_h = hsync;
        prev_v = vsync;
        rises  = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk_dot4x);
            if (vsync && !prev_v) begin
                check_count(rises, 19, "hsync rises from resync to vsync"); // lines 0 to 18
                check_bit(hsync && !prev_h, 1'b1, "hsync rise with vsync rise");
                done = 1'b1;
            end else if (hsync && !prev_h) begin
                rises++;
            end
            prev_h = hsync;
            prev_v = vsync;
        end
    endtask

    task automatic test_line_buffer;
        fill_and_swap(4'd5);
        check_line(4'd5, NTSC_ACTIVE_CYC);
        fill_and_swap(4'd9); // writes the other buffer while 5 is shown
        check_line(4'd9, NTSC_ACTIVE_CYC);
    endtask

    // half_bright at each line start depends on the line just ended
    task automatic test_half_bright;
        int   n;
        logic prev_hb;
        logic prev_h;
        logic seen_active;
        logic seen_blank;
        wait_hsync_entry(1'b1);
        prev_hb    = half_bright;
        seen_blank = 1'b0;
        for (n = 0; n < 264; n++) begin // a full NTSC R8 frame plus one line
            seen_active = 1'b0;
            prev_h      = 1'b1;
            @(negedge clk_dot4x);
            while (!(hsync && !prev_h)) begin
                seen_active = seen_active | active;
                prev_h      = hsync;
                @(negedge clk_dot4x);
            end
            check_bit(half_bright, seen_active ? ~prev_hb : 1'b0, "half_bright at line start");
            seen_blank = seen_blank | ~seen_active;
            prev_hb    = half_bright;
        end
        check_bit(seen_blank, 1'b1, "frame held lines without active video");
    endtask

    // run limit covers all tests with margin
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYC);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        chip         = video_pkg::CHIP_6569R3;
        dot_rising   = 4'b0000;
        native_x_in  = 1'b1;
        native_y_in  = 1'b1;
        hpolarity    = 1'b1;
        vpolarity    = 1'b1;
        enable_csync = 1'b0;
        raster_x     = 10'd1;
        raster_y     = 9'd1;
        pixel_color3 = '0;
        wait (rst == 1'b0);
        test_native_pal;
        test_doubled_ntsc;
        test_polarity_csync;
        test_resync;
        test_line_buffer;
        test_half_bright;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
common/video_pkg.sv
common/scan_timing_pkg.sv
logic/linebuf_ram.sv
scan_timing/timing_table.sv
scan_timing/scan_counter.sv
scan_timing/sync_gen.sv
line_doubler/line_doubler.sv
logic/hires_vga_sync.sv
dv/tb_clock.sv
dv/tb_hires_vga_sync.sv

/* Bender.yml */
package:
  name: hires_vga_sync

sources:
  # packages before the RTL that uses them
  - common/video_pkg.sv
  - common/scan_timing_pkg.sv
  - logic/linebuf_ram.sv
  - scan_timing/timing_table.sv
  - scan_timing/scan_counter.sv
  - scan_timing/sync_gen.sv
  - line_doubler/line_doubler.sv
  - logic/hires_vga_sync.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_hires_vga_sync.sv
